// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = stack_core_tb
FILELIST  = tb.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: logic/bd_merge.sv
module bd_merge (
	input  logic              osc,
	input  logic              rst_n,
	input  bd_pkg::bd_word_t  top_word,
	input  logic              top_valid,
	output logic              top_ready,
	input  bd_pkg::bd_word_t  bot_word,
	input  logic              bot_valid,
	output logic              bot_ready,
	output bd_pkg::bd_word_t  bd_out,        // single word toward the chip
	output logic              bd_out_valid,
	input  logic              bd_out_ready
);

	logic out_free;   // output reg empty or emptying
	logic contend;    // both sides asking
	logic prio_bot;   // bot wins the next contention
	logic grant_top;
	logic grant_bot;
	logic grant_any;

	assign out_free  = !bd_out_valid || bd_out_ready;
	assign contend   = top_valid && bot_valid;
	assign grant_any = grant_top || grant_bot;

	// round robin grant
	always_comb begin
		grant_top = 1'b0;
		grant_bot = 1'b0;
		if (out_free) begin
			if (contend) begin
				grant_bot = prio_bot;
				grant_top = !prio_bot;
			end else begin
				grant_top = top_valid;  // lone requester always wins
				grant_bot = bot_valid;
			end
		end
	end

	// grant doubles as ready
	assign top_ready = grant_top;
	assign bot_ready = grant_bot;

	// control state
	always_ff @(posedge osc) begin
		if (!rst_n) begin
			bd_out_valid <= 1'b0;
			prio_bot     <= 1'b0;  // top first
		end else begin
			if (grant_any)
				bd_out_valid <= 1'b1;
			else if (bd_out_ready)
				bd_out_valid <= 1'b0;

			// pointer only moves on a contended grant
			if (contend && grant_any)
				prio_bot <= !prio_bot;
		end
	end

	// output word
	always_ff @(posedge osc) begin
		if (grant_top)
			bd_out <= top_word;
		else if (grant_bot)
			bd_out <= bot_word;
	end

endmodule

// File: logic/bd_pkg.sv
package bd_pkg;

	// chip side word
	localparam int bd_data_w = 20;               // two body flits
	localparam int bd_half_w = bd_data_w / 2;    // one flit payload

	// which neighbor a word came from
	typedef enum logic {
		side_top = 1'b0,
		side_bot = 1'b1
	} side_e;

	// 21 bit word toward the chip
	typedef struct packed {
		side_e                side;  // source board side
		logic [bd_half_w-1:0] hi;    // first flit of the pair
		logic [bd_half_w-1:0] lo;    // second flit, zero on an odd tail
	} bd_word_t;

endpackage

// File: logic/flit_assembler.sv
module flit_assembler (
	input  logic              osc,
	input  logic              rst_n,
	input  bd_pkg::side_e     side,        // tied per instance
	input  stack_pkg::flit_u  in,          // flits from the neighbor
	input  logic              in_valid,
	output logic              in_ready,
	output stack_pkg::flit_u  fwd,         // pass-through to the far side
	output logic              fwd_valid,
	input  logic              fwd_ready,
	output bd_pkg::bd_word_t  word,        // packed pairs for the chip
	output logic              word_valid,
	input  logic              word_ready
);

	// packet parser states
	typedef enum logic [1:0] {
		st_head,     // waiting on a head flit
		st_collect,  // body flits go to the chip
		st_pass      // body flits go to the far side
	} state_e;

	state_e state;
	state_e state_nxt;

	logic                            hi_full;    // first half of a pair staged
	logic [stack_pkg::payload_w-1:0] hi_q;       // staged first half

	logic fwd_free;   // forward reg can take a flit this cycle
	logic word_free;  // word reg can take a word this cycle
	logic take;       // input handshake
	logic is_tail;
	logic head_bd;    // head asks for chip delivery
	logic fwd_load;
	logic word_load;
	logic hi_load;

	assign fwd_free  = !fwd_valid || fwd_ready;   // empty or draining now
	assign word_free = !word_valid || word_ready;
	assign is_tail   = in.body.tail;              // same bit in the head view
	assign head_bd   = (in.head.route == stack_pkg::route_bd); // 2 and 3 fall to pass
	assign take      = in_valid && in_ready;

	// ready only looks at the register the flit is headed for
	always_comb begin
		in_ready = 1'b1;  // drops and staging never stall
		case (state)
			st_head: begin
				if (!in.head.tail && !head_bd)
					in_ready = fwd_free;  // head is copied forward
			end
			st_collect: begin
				if (hi_full || is_tail)
					in_ready = word_free; // this flit closes a word
			end
			st_pass: begin
				in_ready = fwd_free;
			end
			default: begin
				in_ready = 1'b0;
			end
		endcase
	end

	// next state and load strobes
	always_comb begin
		state_nxt = state;
		fwd_load  = 1'b0;
		word_load = 1'b0;
		hi_load   = 1'b0;
		if (take) begin
			case (state)
				st_head: begin
					if (in.head.tail) begin
						state_nxt = st_head;     // empty packet, dropped
					end else if (head_bd) begin
						state_nxt = st_collect;  // head itself is not delivered
					end else begin
						fwd_load  = 1'b1;        // pass packets keep their head
						state_nxt = st_pass;
					end
				end
				st_collect: begin
					if (hi_full || is_tail)
						word_load = 1'b1;
					else
						hi_load = 1'b1;
					if (is_tail)
						state_nxt = st_head;
				end
				st_pass: begin
					fwd_load = 1'b1;
					if (is_tail)
						state_nxt = st_head;
				end
				default: begin
					state_nxt = st_head;
				end
			endcase
		end
	end

	// control state
	always_ff @(posedge osc) begin
		if (!rst_n) begin
			state      <= st_head;
			hi_full    <= 1'b0;
			fwd_valid  <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			state <= state_nxt;

			if (fwd_load)
				fwd_valid <= 1'b1;
			else if (fwd_ready)
				fwd_valid <= 1'b0;  // taken by the neighbor

			if (word_load)
				word_valid <= 1'b1;
			else if (word_ready)
				word_valid <= 1'b0; // taken by the merge

			if (hi_load)
				hi_full <= 1'b1;
			else if (word_load)
				hi_full <= 1'b0;    // pair closed or odd tail
		end
	end

	// payload registers
	always_ff @(posedge osc) begin
		if (fwd_load)
			fwd <= in;  // unchanged copy
		if (hi_load)
			hi_q <= in.body.data;
		if (word_load) begin
			word.side <= side;
			if (hi_full) begin
				word.hi <= hi_q;          // second flit of the pair
				word.lo <= in.body.data;
			end else begin
				word.hi <= in.body.data;  // odd tail
				word.lo <= '0;
			end
		end
	end

endmodule

// File: logic/stack_core.sv
module stack_core (
	input  logic              osc,
	input  logic              rst_n,
	input  stack_pkg::flit_u  top_in,          // from the board above
	input  logic              top_in_valid,
	output logic              top_in_ready,
	input  stack_pkg::flit_u  bot_in,          // from the board below
	input  logic              bot_in_valid,
	output logic              bot_in_ready,
	output stack_pkg::flit_u  top_out,         // to the board above
	output logic              top_out_valid,
	input  logic              top_out_ready,
	output stack_pkg::flit_u  bot_out,         // to the board below
	output logic              bot_out_valid,
	input  logic              bot_out_ready,
	output bd_pkg::bd_word_t  bd_out,          // to the chip
	output logic              bd_out_valid,
	input  logic              bd_out_ready
);

	// assembler to merge links
	bd_pkg::bd_word_t top_word;
	logic             top_word_valid;
	logic             top_word_ready;
	bd_pkg::bd_word_t bot_word;
	logic             bot_word_valid;
	logic             bot_word_ready;

	// top side, pass traffic leaves at the bottom
	flit_assembler top_assembler (
		.osc        (osc),
		.rst_n      (rst_n),
		.side       (bd_pkg::side_top),
		.in         (top_in),
		.in_valid   (top_in_valid),
		.in_ready   (top_in_ready),
		.fwd        (bot_out),
		.fwd_valid  (bot_out_valid),
		.fwd_ready  (bot_out_ready),
		.word       (top_word),
		.word_valid (top_word_valid),
		.word_ready (top_word_ready)
	);

	// bottom side, pass traffic leaves at the top
	flit_assembler bot_assembler (
		.osc        (osc),
		.rst_n      (rst_n),
		.side       (bd_pkg::side_bot),
		.in         (bot_in),
		.in_valid   (bot_in_valid),
		.in_ready   (bot_in_ready),
		.fwd        (top_out),
		.fwd_valid  (top_out_valid),
		.fwd_ready  (top_out_ready),
		.word       (bot_word),
		.word_valid (bot_word_valid),
		.word_ready (bot_word_ready)
	);

	bd_merge merge (
		.osc          (osc),
		.rst_n        (rst_n),
		.top_word     (top_word),
		.top_valid    (top_word_valid),
		.top_ready    (top_word_ready),
		.bot_word     (bot_word),
		.bot_valid    (bot_word_valid),
		.bot_ready    (bot_word_ready),
		.bd_out       (bd_out),
		.bd_out_valid (bd_out_valid),
		.bd_out_ready (bd_out_ready)
	);

endmodule

// File: logic/stack_pkg.sv
package stack_pkg;

	// board to board link format
	localparam int flit_w = 11;                 // tail + 10 bit payload
	localparam int payload_w = flit_w - 1;      // body data bits
	localparam int tag_w = payload_w - 2;       // head bits left after route

	// route code in the head flit
	// codes 2 and 3 are not named and get the same handling as route_pass
	typedef enum logic [1:0] {
		route_bd   = 2'd0,  // deliver to the chip
		route_pass = 2'd1   // forward to the opposite neighbor
	} route_e;

	// head flit view
	typedef struct packed {
		logic               tail;   // set on an empty packet
		route_e             route;
		logic [tag_w-1:0]   tag;    // opaque, travels with the head
	} flit_head_t;

	// body flit view
	typedef struct packed {
		logic                 tail;  // last flit of the packet
		logic [payload_w-1:0] data;
	} flit_body_t;

	// one link word read two ways
	// the tail bit sits at bit 10 in both views
	typedef union packed {
		flit_head_t head;  // first flit of a packet
		flit_body_t body;  // all flits after it
	} flit_u;

endpackage

// File: tb.f
+incdir+include
logic/stack_pkg.sv
logic/bd_pkg.sv
logic/flit_assembler.sv
logic/bd_merge.sv
logic/stack_core.sv
verification/stack_core_tb.sv

// File: include/stack_tb_checks.svh
`ifndef STACK_TB_CHECKS_SVH
`define STACK_TB_CHECKS_SVH

// galois lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] cur);
	logic [31:0] nxt;
	nxt = cur >> 1;
	if (cur[0])
		nxt = nxt ^ 32'h8020_0003;  // feedback on a shifted out one
	return nxt;
endfunction

// stop on the first mismatch
task automatic fail_now(input string why);
	$display("tests failed");
	$fatal(1, "%s", why);
endtask

// link flit compare
task automatic check_flit(
	input string            name,
	input stack_pkg::flit_u got,
	input stack_pkg::flit_u expected
);
	if (got !== expected) begin
		$display("error %s got %h expected %h", name, got, expected);
		fail_now("flit mismatch");
	end
endtask

// chip word compare with the fields split out
task automatic check_word(
	input string            name,
	input bd_pkg::bd_word_t got,
	input bd_pkg::bd_word_t expected
);
	if (got !== expected) begin
		$display("error %s got %h expected %h", name, got, expected);
		$display("error %s side %h/%h hi %h/%h lo %h/%h", name,
			got.side, expected.side, got.hi, expected.hi, got.lo, expected.lo);
		fail_now("word mismatch");
	end
endtask

// source side of an arbitrated chip word
task automatic check_side(
	input string         name,
	input bd_pkg::side_e got,
	input bd_pkg::side_e expected
);
	if (got !== expected) begin
		$display("error %s got %h expected %h", name, got, expected);
		fail_now("arbiter granted the wrong side");
	end
endtask

`endif

// File: verification/stack_core_tb.sv
module stack_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// table row with idle cycles before the flit
	typedef struct packed {
		bd_pkg::side_e    side;  // which neighbor sends it
		stack_pkg::flit_u flit;
		logic [3:0]       hold;  // valid low this many cycles first
	} row_t;

	logic             osc = 1'b0;
	logic             rst_n;
	stack_pkg::flit_u top_in;
	logic             top_in_valid;
	logic             top_in_ready;
	stack_pkg::flit_u bot_in;
	logic             bot_in_valid;
	logic             bot_in_ready;
	stack_pkg::flit_u top_out;
	logic             top_out_valid;
	logic             top_out_ready;
	stack_pkg::flit_u bot_out;
	logic             bot_out_valid;
	logic             bot_out_ready;
	bd_pkg::bd_word_t bd_out;
	logic             bd_out_valid;
	logic             bd_out_ready;

	row_t             stim[$];          // stimulus table
	stack_pkg::flit_u exp_top_out[$];   // flits due on top_out
	stack_pkg::flit_u exp_bot_out[$];
	bd_pkg::bd_word_t exp_word_top[$];  // chip words from the top side
	bd_pkg::bd_word_t exp_word_bot[$];
	logic [31:0]      lfsr_state = 32'h07c87b90;
	int               settle;
	logic             arb_prio_bot = 1'b0;  // bot wins the next contention
	logic             arb_due = 1'b0;       // contended grant still waiting on bd_out
	bd_pkg::side_e    arb_side = bd_pkg::side_top;

	`include "stack_tb_checks.svh"

	stack_core DUT (
		.osc           (osc),
		.rst_n         (rst_n),
		.top_in        (top_in),
		.top_in_valid  (top_in_valid),
		.top_in_ready  (top_in_ready),
		.bot_in        (bot_in),
		.bot_in_valid  (bot_in_valid),
		.bot_in_ready  (bot_in_ready),
		.top_out       (top_out),
		.top_out_valid (top_out_valid),
		.top_out_ready (top_out_ready),
		.bot_out       (bot_out),
		.bot_out_valid (bot_out_valid),
		.bot_out_ready (bot_out_ready),
		.bd_out        (bd_out),
		.bd_out_valid  (bd_out_valid),
		.bd_out_ready  (bd_out_ready)
	);

	always #4 osc = ~osc;  // 8 ns period

	function automatic stack_pkg::flit_u head_flit(input logic tail, input logic [1:0] route,
			input logic [7:0] tag);
		stack_pkg::flit_u f;
		f.head.tail  = tail;
		f.head.route = stack_pkg::route_e'(route);  // unnamed codes 2 and 3 too
		f.head.tag   = tag;
		return f;
	endfunction

	function automatic stack_pkg::flit_u body_flit(input logic tail, input logic [9:0] data);
		stack_pkg::flit_u f;
		f.body.tail = tail;
		f.body.data = data;
		return f;
	endfunction

	task automatic add_row(input bd_pkg::side_e s, input stack_pkg::flit_u f, input int hold);
		row_t r;
		r.side = s;
		r.flit = f;
		r.hold = hold[3:0];
		stim.push_back(r);
	endtask

	task automatic load_table();
		bd_pkg::side_e t;
		bd_pkg::side_e b;
		t = bd_pkg::side_top;
		b = bd_pkg::side_bot;
		add_row(t, head_flit(1'b1, 2'd0, 8'h11), 0);   // empty packets right after reset
		add_row(b, head_flit(1'b1, 2'd1, 8'h12), 0);
		add_row(t, head_flit(1'b0, 2'd0, 8'h21), 0);   // even chip packet
		add_row(t, body_flit(1'b0, 10'h155), 0);
		add_row(t, body_flit(1'b0, 10'h0aa), 0);
		add_row(t, body_flit(1'b0, 10'h3ff), 0);
		add_row(t, body_flit(1'b1, 10'h001), 0);
		add_row(b, head_flit(1'b0, 2'd0, 8'h22), 0);   // odd chip packet alongside
		add_row(b, body_flit(1'b0, 10'h2c3), 0);
		add_row(b, body_flit(1'b0, 10'h13c), 0);
		add_row(b, body_flit(1'b1, 10'h0f0), 0);
		add_row(t, head_flit(1'b0, 2'd1, 8'h5a), 2);   // pass to bot_out
		add_row(t, body_flit(1'b0, 10'h010), 0);
		add_row(t, body_flit(1'b0, 10'h020), 1);
		add_row(t, body_flit(1'b1, 10'h030), 0);
		add_row(b, head_flit(1'b0, 2'd1, 8'ha5), 1);   // short pass to top_out
		add_row(b, body_flit(1'b1, 10'h077), 0);
		add_row(t, head_flit(1'b0, 2'd3, 8'h33), 0);   // unnamed code still passes
		add_row(t, body_flit(1'b1, 10'h3c3), 3);
		add_row(b, head_flit(1'b0, 2'd2, 8'h44), 0);
		add_row(b, body_flit(1'b0, 10'h101), 0);
		add_row(b, body_flit(1'b1, 10'h202), 0);
		add_row(t, head_flit(1'b0, 2'd0, 8'h61), 0);   // single body flit
		add_row(t, body_flit(1'b1, 10'h2aa), 0);
		add_row(b, head_flit(1'b1, 2'd0, 8'h62), 0);   // empty chip packet mid stream
		add_row(b, head_flit(1'b0, 2'd0, 8'h63), 2);
		add_row(b, body_flit(1'b0, 10'h111), 0);
		add_row(b, body_flit(1'b1, 10'h222), 0);
		add_row(t, head_flit(1'b0, 2'd0, 8'h64), 0);
		add_row(t, body_flit(1'b0, 10'h3a5), 0);
		add_row(t, body_flit(1'b0, 10'h05a), 0);
		add_row(t, body_flit(1'b0, 10'h1e1), 0);
		add_row(t, body_flit(1'b1, 10'h2d2), 0);
	endtask

	// reference model walks each side's packets in table order
	task automatic build_expected();
		int               mode[2];   // 0 head, 1 chip, 2 pass
		logic             have_hi[2];
		logic [9:0]       hi_data[2];
		int               s;
		stack_pkg::flit_u f;
		bd_pkg::bd_word_t w;
		mode    = '{0, 0};
		have_hi = '{1'b0, 1'b0};
		hi_data = '{10'h0, 10'h0};
		foreach (stim[i]) begin
			s = int'(stim[i].side);
			f = stim[i].flit;
			w.side = stim[i].side;
			if (mode[s] == 0) begin
				if (f.head.tail)
					mode[s] = 0;  // empty packet vanishes
				else if (f.head.route == stack_pkg::route_bd)
					mode[s] = 1;
				else begin
					mode[s] = 2;
					if (s == 0)
						exp_bot_out.push_back(f);  // head goes across too
					else
						exp_top_out.push_back(f);
				end
			end else if (mode[s] == 1) begin
				if (have_hi[s] || f.body.tail) begin
					w.hi = have_hi[s] ? hi_data[s] : f.body.data;
					w.lo = have_hi[s] ? f.body.data : 10'h0;  // odd tail pads lo
					have_hi[s] = 1'b0;
					if (s == 0)
						exp_word_top.push_back(w);
					else
						exp_word_bot.push_back(w);
				end else begin
					have_hi[s] = 1'b1;
					hi_data[s] = f.body.data;
				end
				if (f.body.tail)
					mode[s] = 0;
			end else begin
				if (s == 0)
					exp_bot_out.push_back(f);
				else
					exp_top_out.push_back(f);
				if (f.body.tail)
					mode[s] = 0;
			end
		end
	endtask

	task automatic set_in(input bd_pkg::side_e s, input stack_pkg::flit_u f, input logic v);
		if (s == bd_pkg::side_top) begin
			top_in       = f;
			top_in_valid = v;
		end else begin
			bot_in       = f;
			bot_in_valid = v;
		end
	endtask

	// walks the table for one side starting on a falling edge
	task automatic drive_side(input bd_pkg::side_e s);
		int   waited;
		logic done;
		foreach (stim[i]) begin
			if (stim[i].side == s) begin
				set_in(s, '0, 1'b0);
				repeat (stim[i].hold) @(negedge osc);
				set_in(s, stim[i].flit, 1'b1);
				waited = 0;
				done   = 1'b0;
				while (!done && waited < 200) begin
					@(posedge osc);
					done   = (s == bd_pkg::side_top) ? top_in_ready : bot_in_ready;
					waited = waited + 1;
				end
				if (!done)
					fail_now("input flit was never accepted, timeout on in_ready");
				@(negedge osc);
			end
		end
		set_in(s, '0, 1'b0);
	endtask

	function automatic int queues_left();
		return exp_top_out.size() + exp_bot_out.size() + exp_word_top.size()
			+ exp_word_bot.size();
	endfunction

	// random back-pressure with one lfsr step per ready bit
	always @(negedge osc) begin
		lfsr_state    = lfsr_next(lfsr_state);
		top_out_ready = lfsr_state[0];
		lfsr_state    = lfsr_next(lfsr_state);
		bot_out_ready = lfsr_state[0];
		lfsr_state    = lfsr_next(lfsr_state);
		bd_out_ready  = lfsr_state[0];
	end

	// monitors sample before the edge updates the DUT
	always @(posedge osc) begin
		if (rst_n) begin
			if (top_out_valid && top_out_ready) begin
				if (exp_top_out.size() == 0)
					fail_now("unexpected flit on top_out");
				else
					check_flit("top_out", top_out, exp_top_out.pop_front());
			end
			if (bot_out_valid && bot_out_ready) begin
				if (exp_bot_out.size() == 0)
					fail_now("unexpected flit on bot_out");
				else
					check_flit("bot_out", bot_out, exp_bot_out.pop_front());
			end
			if (bd_out_valid && bd_out_ready) begin
				if (arb_due) begin
					check_side("bd_out.side", bd_out.side, arb_side);  // contended winner
					arb_due = 1'b0;
				end
				if (bd_out.side == bd_pkg::side_top) begin
					if (exp_word_top.size() == 0)
						fail_now("unexpected top side word on bd_out");
					else
						check_word("bd_out", bd_out, exp_word_top.pop_front());
				end else begin
					if (exp_word_bot.size() == 0)
						fail_now("unexpected bot side word on bd_out");
					else
						check_word("bd_out", bd_out, exp_word_bot.pop_front());
				end
			end
			// round robin model
			// both sides offer a word while the merge reg can load
			if (DUT.top_word_valid && DUT.bot_word_valid
					&& (!bd_out_valid || bd_out_ready)) begin
				arb_side     = arb_prio_bot ? bd_pkg::side_bot : bd_pkg::side_top;
				arb_prio_bot = !arb_prio_bot;
				arb_due      = 1'b1;  // next bd_out word must come from arb_side
			end
		end
	end

	initial begin
		rst_n         = 1'b0;
		top_in        = '0;
		top_in_valid  = 1'b0;
		bot_in        = '0;
		bot_in_valid  = 1'b0;
		top_out_ready = 1'b0;
		bot_out_ready = 1'b0;
		bd_out_ready  = 1'b0;
		load_table();
		build_expected();
		repeat (4) @(posedge osc);
		@(negedge osc);
		rst_n = 1'b1;
		if (top_out_valid || bot_out_valid || bd_out_valid)
			fail_now("an output valid was high right after reset");
		fork
			drive_side(bd_pkg::side_top);
			drive_side(bd_pkg::side_bot);
		join
		settle = 0;
		while (queues_left() != 0 && settle < 2000) begin
			@(negedge osc);
			settle = settle + 1;
		end
		repeat (20) @(negedge osc);  // stray outputs would show here
		if (queues_left() == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			fail_now("timeout, expected outputs never arrived");
		end
	end

endmodule
